/* source/ramtest_macros.svh */
// ramtest sizing: block size, FIFO depths, headroom, memory depth and latencies
`ifndef RAMTEST_MACROS_SVH
`define RAMTEST_MACROS_SVH

// host side, counted in 32-bit words
`define RT_BLOCK_WORDS 16  // 4 beats per block
`define RT_IN_DEPTH 64     // pipe-in capacity
`define RT_OUT_DEPTH 64    // pipe-out capacity
`define RT_HEADROOM 4      // slack on top of one block before pipe-in ready

// memory side, counted in 128-bit beats
`define RT_MEM_BEATS 256
`define RT_ADDR_W 8

// timing, in okClk cycles
`define RT_RD_LATENCY 3     // accepted read to rd_valid
`define RT_CALIB_CYCLES 20  // reset release to calib_done

`endif

/* source/ramtest_pkg.sv */
// ramtest types: memory command and sequencer state enums, control, request and response structs
`include "ramtest_macros.svh"

package ramtest_pkg;

	// ----------------------------------------
	// enums
	// ----------------------------------------

	// app_cmd encoding as seen by the controller
	typedef enum logic [2:0] {
		CMD_WRITE = 3'd0,
		CMD_READ  = 3'd1
	} app_cmd_e;

	typedef enum logic [1:0] {
		S_IDLE,       // pick next command
		S_WRITE,      // write beat on the bus
		S_READ,       // read command on the bus
		S_WAIT_CALIB  // hold off until memory is up
	} seq_state_e;

	// ----------------------------------------
	// structs
	// ----------------------------------------

	// wire-in control, reads_en lands on bit 0
	typedef struct packed {
		logic soft_reset;  // bit 2
		logic writes_en;   // bit 1
		logic reads_en;    // bit 0
	} ctrl_t;

	// command plus write data, presented together
	typedef struct packed {
		logic                  en;
		app_cmd_e              cmd;
		logic [`RT_ADDR_W-1:0] addr;   // beat address
		logic [127:0]          wdata;  // taken when cmd is a write
	} app_req_t;

	typedef struct packed {
		logic         rdy;       // command slot open
		logic         wdf_rdy;   // write data slot open
		logic         rd_valid;  // one-cycle pulse
		logic [127:0] rd_data;
	} app_rsp_t;

endpackage

/* source/pipe_in_fifo.sv */
// pipe-in FIFO: packs 32-bit host words into 128-bit beats, fill count and block-space ready
`timescale 1ns/1ps
`include "ramtest_macros.svh"

module pipe_in_fifo (
	input  logic         okClk,
	input  logic         rst_n,
	input  logic         soft_reset,
	input  logic         write,
	input  logic [31:0]  wdata,
	input  logic         pop,
	output logic [127:0] beat,
	output logic [4:0]   beats,
	output logic         ready
);
	localparam int NBEATS = `RT_IN_DEPTH / 4;      // ring size in beats
	localparam int PW     = $clog2(NBEATS);        // pointers wrap on their own
	localparam int CW     = $clog2(`RT_IN_DEPTH + 1);

	logic [127:0]  mem [NBEATS];
	logic [PW-1:0] wr_ptr;      // beat being filled
	logic [PW-1:0] rd_ptr;      // head beat
	logic [1:0]    wr_lane;     // next 32-bit lane, low first
	logic [CW-1:0] words;       // includes the partial beat
	logic [4:0]    full_beats;  // complete beats only
	logic [CW-1:0] free_words;
	logic          do_write;
	logic          do_pop;

	assign do_write   = write && (words != CW'(`RT_IN_DEPTH)); // never past full
	assign do_pop     = pop && (full_beats != '0);
	assign free_words = CW'(`RT_IN_DEPTH) - words;
	assign beat       = mem[rd_ptr];  // head shows without a read
	assign beats      = full_beats;

	// ----------------------------------------
	// storage, one lane per host word
	// ----------------------------------------
	always_ff @(posedge okClk) begin
		if (do_write) begin
			mem[wr_ptr][wr_lane*32 +: 32] <= wdata;
		end
	end

	// ----------------------------------------
	// pointers, counts, throttle
	// ----------------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n || soft_reset) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			wr_lane    <= '0;
			words      <= '0;
			full_beats <= '0;
			ready      <= 1'b0;
		end else begin
			if (do_write) begin
				wr_lane <= wr_lane + 2'd1;
				if (wr_lane == 2'd3)
					wr_ptr <= wr_ptr + 1'b1;  // beat complete
			end
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// word count moves in the write cycle
			words <= words + CW'(do_write) - (do_pop ? CW'(4) : CW'(0));
			full_beats <= full_beats + 5'(do_write && (wr_lane == 2'd3)) - 5'(do_pop);
			// room for a whole block plus slack
			ready <= (free_words >= CW'(`RT_BLOCK_WORDS + `RT_HEADROOM));
		end
	end

endmodule

/* source/pipe_out_fifo.sv */
// pipe-out FIFO: 128-bit read beats out as 32-bit fall-through words, read reservations, block ready
`timescale 1ns/1ps
`include "ramtest_macros.svh"

module pipe_out_fifo (
	input  logic         okClk,
	input  logic         rst_n,
	input  logic         soft_reset,
	input  logic         push,
	input  logic [127:0] beat,
	input  logic         read_issue,
	input  logic         read,
	output logic [31:0]  rdata,
	output logic [4:0]   space_beats,
	output logic         ready
);
	localparam int NBEATS = `RT_OUT_DEPTH / 4;
	localparam int PW     = $clog2(NBEATS);
	localparam int CW     = $clog2(`RT_OUT_DEPTH + 1);
	localparam int BW     = $clog2(NBEATS + 1);  // 5, matches space_beats

	logic [127:0]  mem [NBEATS];
	logic [PW-1:0] wr_ptr;
	logic [PW-1:0] rd_ptr;
	logic [1:0]    rd_lane;  // lane on rdata
	logic [CW-1:0] words;    // stored words not yet read
	logic [BW-1:0] occ;      // beats holding any unread lane
	logic [BW-1:0] rsv;      // beats owed to reads in flight
	logic          do_read;
	logic          last_lane;

	assign do_read     = read && (words != '0);
	assign last_lane   = do_read && (rd_lane == 2'd3);  // frees the head beat
	assign rdata       = mem[rd_ptr][rd_lane*32 +: 32];
	assign space_beats = BW'(NBEATS) - occ - rsv;

	always_ff @(posedge okClk) begin
		if (push)
			mem[wr_ptr] <= beat;
	end

	// ----------------------------------------
	// bookkeeping
	// ----------------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n || soft_reset) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			rd_lane <= '0;
			words   <= '0;
			occ     <= '0;
			rsv     <= '0;
			ready   <= 1'b0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_lane <= rd_lane + 2'd1;
			if (last_lane)
				rd_ptr <= rd_ptr + 1'b1;
			words <= words + (push ? CW'(4) : CW'(0)) - CW'(do_read);
			occ   <= occ + BW'(push) - BW'(last_lane);
			// a returning beat turns its reservation into storage
			rsv   <= rsv + BW'(read_issue) - BW'(push && (rsv != '0));
			ready <= (words >= CW'(`RT_BLOCK_WORDS));  // whole block waiting
		end
	end

endmodule

/* source/ram_test_seq.sv */
// RAM test sequencer: write/read command FSM, address counters, readback into pipe-out
`timescale 1ns/1ps
`include "ramtest_macros.svh"

module ram_test_seq
	import ramtest_pkg::*;
(
	input  logic         okClk,
	input  logic         rst_n,
	input  ctrl_t        ctrl,
	input  logic         calib_done,
	input  logic [127:0] in_beat,
	input  logic [4:0]   in_beats,
	output logic         in_pop,
	input  logic [4:0]   out_space_beats,
	output logic         read_issue,
	output logic         out_push,
	output logic [127:0] out_beat,
	output app_req_t     req,
	input  app_rsp_t     rsp
);
	localparam int AW = `RT_ADDR_W;

	seq_state_e    state;
	seq_state_e    state_nxt;
	logic [AW-1:0] wr_addr;
	logic [AW-1:0] rd_addr;
	logic          prio_rd;   // reads win the next tie
	logic [1:0]    inflight;  // reads accepted, data not back yet
	logic [1:0]    stale;     // returns to drop after a soft reset
	logic          want_wr;
	logic          want_rd;
	logic          active;
	logic          wr_acc;
	logic          rd_acc;

	// next beat address, wraps at the memory top
	function automatic logic [AW-1:0] addr_inc(input logic [AW-1:0] a);
		return (a == AW'(`RT_MEM_BEATS - 1)) ? '0 : a + 1'b1;
	endfunction

	assign want_wr = ctrl.writes_en && (in_beats != '0);        // whole beat ready
	assign want_rd = ctrl.reads_en && (out_space_beats != '0);  // room incl. in flight
	assign active  = ((state == S_WRITE) || (state == S_READ)) && !ctrl.soft_reset;

	// command held on the bus until taken
	always_comb begin
		req.en    = active;
		req.cmd   = (state == S_READ) ? CMD_READ : CMD_WRITE;
		req.addr  = (state == S_READ) ? rd_addr : wr_addr;
		req.wdata = in_beat;  // wdf_wren follows en for writes
	end

	assign wr_acc     = active && (state == S_WRITE) && rsp.rdy && rsp.wdf_rdy;
	assign rd_acc     = active && (state == S_READ) && rsp.rdy;
	assign in_pop     = wr_acc;
	assign read_issue = rd_acc;  // pipe-out reserves a beat
	assign out_push   = rsp.rd_valid && (stale == '0);
	assign out_beat   = rsp.rd_data;

	// ----------------------------------------
	// next state
	// ----------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			S_WAIT_CALIB: begin
				if (calib_done)
					state_nxt = S_IDLE;
			end
			S_IDLE: begin
				if (want_wr && want_rd)
					state_nxt = prio_rd ? S_READ : S_WRITE;  // alternate
				else if (want_wr)
					state_nxt = S_WRITE;
				else if (want_rd)
					state_nxt = S_READ;
			end
			S_WRITE: if (wr_acc) state_nxt = S_IDLE;
			S_READ:  if (rd_acc) state_nxt = S_IDLE;
			default: state_nxt = S_WAIT_CALIB;
		endcase
	end

	// ----------------------------------------
	// state, addresses, priority
	// ----------------------------------------
	always_ff @(posedge okClk) begin
		if (!rst_n || ctrl.soft_reset) begin
			state   <= S_WAIT_CALIB;  // passes straight on if already calibrated
			wr_addr <= '0;
			rd_addr <= '0;
			prio_rd <= 1'b0;
		end else begin
			state <= state_nxt;
			if (wr_acc) begin
				wr_addr <= addr_inc(wr_addr);
				prio_rd <= 1'b1;
			end
			if (rd_acc) begin
				rd_addr <= addr_inc(rd_addr);
				prio_rd <= 1'b0;
			end
		end
	end

	// reads still in flight at a soft reset are old data, flushed here
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			inflight <= '0;
			stale    <= '0;
		end else begin
			inflight <= inflight + 2'(rd_acc) - 2'(rsp.rd_valid);
			if (ctrl.soft_reset)
				stale <= inflight - 2'(rsp.rd_valid);
			else if (rsp.rd_valid && (stale != '0))
				stale <= stale - 2'd1;
		end
	end

endmodule

/* source/ui_memory.sv */
// on-chip beat memory behind a controller-style app interface: busy gap, read pipe, calibration
`timescale 1ns/1ps
`include "ramtest_macros.svh"

module ui_memory
	import ramtest_pkg::*;
(
	input  logic     okClk,
	input  logic     rst_n,
	input  app_req_t req,
	output app_rsp_t rsp,
	output logic     calib_done
);
	localparam int LAT = `RT_RD_LATENCY;
	localparam int CCW = $clog2(`RT_CALIB_CYCLES + 1);

	logic [127:0]   mem [`RT_MEM_BEATS];  // kept across reset
	logic [CCW-1:0] cal_cnt;
	logic           gap;     // busy cycle after a command
	logic           rdy;
	logic           accept;
	logic [LAT-1:0] rd_vld;  // read pipe, stage 0 first
	logic [127:0]   rd_dat [LAT];

	assign rdy    = calib_done && !gap;
	assign accept = req.en && rdy;  // wdf_rdy tracks rdy

	always_comb begin
		rsp.rdy      = rdy;
		rsp.wdf_rdy  = rdy;
		rsp.rd_valid = rd_vld[LAT-1];
		rsp.rd_data  = rd_dat[LAT-1];
	end

	// calibration timer, then one command per two cycles at most
	always_ff @(posedge okClk) begin
		if (!rst_n) begin
			cal_cnt    <= '0;
			calib_done <= 1'b0;
			gap        <= 1'b0;
			rd_vld     <= '0;
		end else begin
			if (!calib_done) begin
				cal_cnt <= cal_cnt + 1'b1;
				if (cal_cnt == CCW'(`RT_CALIB_CYCLES - 1))
					calib_done <= 1'b1;
			end
			gap    <= accept;
			rd_vld <= {rd_vld[LAT-2:0], accept && (req.cmd == CMD_READ)};
		end
	end

	// array and read data, no reset
	always_ff @(posedge okClk) begin
		if (accept && (req.cmd == CMD_WRITE))
			mem[req.addr] <= req.wdata;  // mask always open
		rd_dat[0] <= mem[req.addr];
		for (int i = 1; i < LAT; i++)
			rd_dat[i] <= rd_dat[i-1];
	end

endmodule

/* source/ramtest_core.sv */
// ramtest top: pipe FIFOs, test sequencer and on-chip memory wired together
`timescale 1ns/1ps

module ramtest_core
	import ramtest_pkg::*;
(
	input  logic        okClk,
	input  logic        rst_n,
	input  ctrl_t       ctrl,
	input  logic        pipe_in_write,
	input  logic [31:0] pipe_in_data,
	output logic        pipe_in_ready,
	input  logic        pipe_out_read,
	output logic [31:0] pipe_out_data,
	output logic        pipe_out_ready,
	output logic        calib_done
);
	// pipe-in to sequencer
	logic         in_pop;
	logic [127:0] in_beat;
	logic [4:0]   in_beats;
	// sequencer to pipe-out
	logic         out_push;
	logic [127:0] out_beat;
	logic         read_issue;
	logic [4:0]   out_space_beats;
	// app interface
	app_req_t     app_req;
	app_rsp_t     app_rsp;

	pipe_in_fifo u_pipe_in_fifo (
		.okClk(okClk), .rst_n(rst_n), .soft_reset(ctrl.soft_reset),
		.write(pipe_in_write), .wdata(pipe_in_data),
		.pop(in_pop), .beat(in_beat), .beats(in_beats),
		.ready(pipe_in_ready)
	);

	pipe_out_fifo u_pipe_out_fifo (
		.okClk(okClk), .rst_n(rst_n), .soft_reset(ctrl.soft_reset),
		.push(out_push), .beat(out_beat), .read_issue(read_issue),
		.read(pipe_out_read), .rdata(pipe_out_data),
		.space_beats(out_space_beats), .ready(pipe_out_ready)
	);

	ram_test_seq u_ram_test_seq (
		.okClk(okClk), .rst_n(rst_n), .ctrl(ctrl), .calib_done(calib_done),
		.in_beat(in_beat), .in_beats(in_beats), .in_pop(in_pop),
		.out_space_beats(out_space_beats), .read_issue(read_issue),
		.out_push(out_push), .out_beat(out_beat),
		.req(app_req), .rsp(app_rsp)
	);

	// memory ignores soft reset, contents and calibration stay
	ui_memory u_ui_memory (
		.okClk(okClk), .rst_n(rst_n),
		.req(app_req), .rsp(app_rsp), .calib_done(calib_done)
	);

endmodule

/* tests/tb_ramtest.sv */
// ramtest_core testbench with pipe streaming from the data file plus readback, throttle and soft reset checks
`timescale 1ns/1ps
`include "ramtest_macros.svh"

module tb_ramtest
	import ramtest_pkg::*;
();
	localparam int CLK_HALF   = 2;    // 4 ns period
	localparam int TIMEOUT    = 400;  // cycles allowed per wait
	localparam int SETTLE     = `RT_RD_LATENCY + 4;  // read pipe plus accept, push and ready stages
	localparam int W_IN_RDY   = 0;
	localparam int W_OUT_RDY  = 1;
	localparam int W_CALIB    = 2;
	localparam int W_IN_EMPTY = 3;

	logic        okClk = 1'b0;
	logic        rst_n;
	ctrl_t       ctrl;
	logic        pipe_in_write;
	logic [31:0] pipe_in_data;
	logic        pipe_in_ready;
	logic        pipe_out_read;
	logic [31:0] pipe_out_data;
	logic        pipe_out_ready;
	logic        calib_done;

	logic [31:0] tdata [0:4*`RT_BLOCK_WORDS];  // block count followed by words
	logic [15:0] lfsr   = 16'd21016;
	int          nblocks;
	int          errors = 0;
	int          checks = 0;
	bit          aborted = 1'b0;  // set once a wait has expired

	always #(CLK_HALF) okClk = ~okClk;

	ramtest_core u_ramtest_core (
		.okClk, .rst_n, .ctrl, .pipe_in_write, .pipe_in_data, .pipe_in_ready,
		.pipe_out_read, .pipe_out_data, .pipe_out_ready, .calib_done
	);

	// ----------------------------------------
	// helpers
	// ----------------------------------------

	// galois taps for x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic idle_gap();
		int n;
		n = 0;
		repeat (2) begin
			n = (n << 1) | int'(lfsr[0]);  // one step per bit
			lfsr = lfsr_next(lfsr);
		end
		repeat (n) @(posedge okClk);  // 0 to 3 idle cycles
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic report_and_finish();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	function automatic logic probe(input int which);
		case (which)
			W_IN_RDY:  return pipe_in_ready;
			W_OUT_RDY: return pipe_out_ready;
			W_CALIB:   return calib_done;
			default:   return (u_ramtest_core.in_beats == 5'd0);  // all beats in memory
		endcase
	endfunction

	// sampled on the falling edge away from the drive edge
	task automatic wait_level(input int which, input string what);
		int n;
		n = 0;
		@(negedge okClk);
		while (!aborted && !probe(which) && n < TIMEOUT) begin
			@(negedge okClk);
			n++;
		end
		if (!aborted && !probe(which)) begin
			errors++;
			aborted = 1'b1;
			$display("timeout waiting for %s after %0d cycles", what, TIMEOUT);
		end
	endtask

	task automatic set_ctrl(input logic sr, input logic we, input logic re);
		@(posedge okClk);
		ctrl.soft_reset <= sr;
		ctrl.writes_en  <= we;
		ctrl.reads_en   <= re;
	endtask

	task automatic pulse_soft_reset();
		set_ctrl(1'b1, 1'b0, 1'b0);
		set_ctrl(1'b0, 1'b0, 1'b0);
		repeat (2) @(posedge okClk);  // sequencer back in idle
	endtask

	task automatic push_block(input int b, input bit gaps);
		for (int i = 0; i < `RT_BLOCK_WORDS; i++) begin
			@(posedge okClk);
			pipe_in_write <= 1'b1;  // one-cycle strobe
			pipe_in_data  <= tdata[1 + b*`RT_BLOCK_WORDS + i];
			@(posedge okClk);
			pipe_in_write <= 1'b0;
			if (gaps)
				idle_gap();
		end
	endtask

	// fall-through head word is valid before the strobe
	task automatic pop_block(input int b);
		for (int i = 0; i < `RT_BLOCK_WORDS; i++) begin
			@(negedge okClk);
			check("pipe_out_data", pipe_out_data, tdata[1 + b*`RT_BLOCK_WORDS + i]);
			@(posedge okClk);
			pipe_out_read <= 1'b1;
			@(posedge okClk);
			pipe_out_read <= 1'b0;
		end
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	task automatic run_tests();
		int blocks;
		int unread;
		int p;
		int wb;
		int rb;

		// 1. reset values and calibration
		@(negedge okClk);
		check("pipe_out_ready", 32'(pipe_out_ready), 32'd0);
		check("calib_done", 32'(calib_done), 32'd0);
		wait_level(W_IN_RDY, "pipe_in_ready after reset");
		wait_level(W_CALIB, "calib_done");

		// 2. all blocks into memory and back out from address 0
		set_ctrl(1'b0, 1'b1, 1'b0);
		for (wb = 0; wb < nblocks; wb++) begin
			wait_level(W_IN_RDY, "pipe_in_ready");
			push_block(wb, 1'b1);
		end
		wait_level(W_IN_EMPTY, "pipe-in FIFO to drain");
		set_ctrl(1'b0, 1'b0, 1'b1);
		for (rb = 0; rb < nblocks; rb++) begin
			wait_level(W_OUT_RDY, "pipe_out_ready");
			pop_block(rb);
		end
		set_ctrl(1'b0, 1'b0, 1'b0);

		// 3. count blocks until throttled with nothing draining
		blocks = 0;
		while (blocks < 8) begin
			@(negedge okClk);
			if (!pipe_in_ready)
				break;
			push_block(blocks % nblocks, 1'b0);
			blocks++;
			@(posedge okClk);  // ready registers off the new count
		end
		check("blocks_accepted", blocks, (`RT_IN_DEPTH - `RT_HEADROOM) / `RT_BLOCK_WORDS);
		pulse_soft_reset();

		// 4. one beat per reads_en pulse with ready held off below a block
		for (p = 1; p <= `RT_BLOCK_WORDS / 4; p++) begin
			set_ctrl(1'b0, 1'b0, 1'b1);  // reads_en for one idle cycle gives one read
			set_ctrl(1'b0, 1'b0, 1'b0);
			unread = p * 4;
			repeat (SETTLE) begin
				@(negedge okClk);
				if (unread < `RT_BLOCK_WORDS)
					check("pipe_out_ready", 32'(pipe_out_ready), 32'd0);
			end
		end
		wait_level(W_OUT_RDY, "pipe_out_ready after a whole block");

		// 5. soft reset clears addresses and keeps memory
		pulse_soft_reset();
		set_ctrl(1'b0, 1'b0, 1'b1);
		wait_level(W_OUT_RDY, "pipe_out_ready after soft reset");
		pop_block(0);
		set_ctrl(1'b0, 1'b0, 1'b0);

		// 6. both directions at once
		// reads may run ahead of writes and find the same words already in memory
		pulse_soft_reset();
		set_ctrl(1'b0, 1'b1, 1'b1);
		fork
			for (wb = 0; wb < nblocks; wb++) begin
				wait_level(W_IN_RDY, "pipe_in_ready while streaming");
				push_block(wb, 1'b1);
			end
			for (rb = 0; rb < nblocks; rb++) begin
				wait_level(W_OUT_RDY, "pipe_out_ready while streaming");
				pop_block(rb);
			end
		join
		set_ctrl(1'b0, 1'b0, 1'b0);
	endtask

	initial begin
		rst_n         = 1'b0;
		ctrl          = '0;
		pipe_in_write = 1'b0;
		pipe_in_data  = '0;
		pipe_out_read = 1'b0;
		$readmemh("tests/ramtest_testdata.hex", tdata);
		nblocks = int'(tdata[0]);
		repeat (3) @(posedge okClk);
		rst_n <= 1'b1;
		if (nblocks < 1 || nblocks > 4) begin
			errors++;
			$display("data file holds %0d blocks but only 1 to 4 fit", nblocks);
		end else begin
			run_tests();
		end
		report_and_finish();
	end

endmodule

/* tests/ramtest_testdata.hex */
// entry 0 is the block count, then 32-bit pipe-in words in host order, four per line
4
a5a50000 5a5a0001 deadbeef 01234567
89abcdef fedcba98 76543210 0f0f0f0f
f0f0f0f0 33cc33cc cc33cc33 00000000
ffffffff 80000001 7ffffffe 12345678
c001d00d 0badf00d 13579bdf 2468ace0
11111111 22222222 44444444 88888888
a0b1c2d3 e4f5a6b7 c8d9eaf1 02132435
46576879 8a9bacbd cedfe0f1 55aa55aa
aa55aa55 00ff00ff ff00ff00 10203040
50607080 90a0b0c0 d0e0f001 6b8b4567
327b23c6 643c9869 66334873 74b0dc51
19495cff 2ae8944a 625558ec 238e1f29
46e87ccd 3d1b58ba 507ed7ab 2eb141f2
41b71efb 79e2a9e3 7545e146 515f007c
5bd062c2 12200854 4db127f8 0216231b
1f16e9e8 1190cde7 66ef438d 140e0f76

/* compile.f */
+incdir+source
source/ramtest_pkg.sv
source/pipe_in_fifo.sv
source/pipe_out_fifo.sv
source/ram_test_seq.sv
source/ui_memory.sv
source/ramtest_core.sv
tests/tb_ramtest.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_ramtest
FILELIST  := compile.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard source/*.sv source/*.svh tests/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(OBJDIR) $(LOG)
